/* files.f */
+incdir+design
design/byteFifo.sv
design/usbFifoPkg.sv
design/hostCmdPkg.sv
design/rxPort.sv
design/txPort.sv
design/hostControl.sv
design/usbFifoTop.sv
test/usbFifoChecker.sv
test/usbFifoTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= usbFifoTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "sim: pass"; \
	else \
		echo "sim: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/usbFifoTb.sv */
`timescale 1ns/1ps

module usbFifoTb;

    typedef enum logic [2:0] {
        ACT_RECV, ACT_GRANT, ACT_CLEAR, ACT_READ, ACT_WRITE, ACT_TAKE, ACT_IDLE
    } action_e;

    typedef struct packed {
        action_e    act;
        logic [7:0] arg;      // byte, credit or idle cycles
        logic       flagLow;  // bus cycles wait for a low flag, else strobe against it
    } step_t;

    logic               _RD;
    logic               arstN;
    logic               rdN;
    logic               wr;
    logic [7:0]         dataIn;
    logic               cmdValid;
    hostCmdPkg::cmdOp_e cmdOp;
    logic [7:0]         cmdArg;
    logic               txTake;
    logic [7:0]         dataOut;
    logic               dataOe;
    logic               rxfN;
    logic               txeN;
    logic               errRead;
    logic               errWrite;
    logic [7:0]         txByte;
    logic               txValid;
    logic [7:0]         dropCount;
    int                 errorCount;
    int                 tbErrors = 0;
    int                 cycles = 0;
    int                 cycleLimit = 0;
    int                 seed;
    step_t              steps[$];

    usbFifoTop u_usbFifoTop (
        ._RD(_RD), .arstN(arstN), .rdN(rdN), .wr(wr), .dataIn(dataIn),
        .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdArg(cmdArg), .txTake(txTake),
        .dataOut(dataOut), .dataOe(dataOe), .rxfN(rxfN), .txeN(txeN), .errRead(errRead),
        .errWrite(errWrite), .txByte(txByte), .txValid(txValid), .dropCount(dropCount)
    );

    usbFifoChecker refCheck (
        ._RD(_RD), .arstN(arstN), .rdN(rdN), .wr(wr), .dataIn(dataIn),
        .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdArg(cmdArg), .txTake(txTake),
        .dataOut(dataOut), .dataOe(dataOe), .rxfN(rxfN), .txeN(txeN), .errRead(errRead),
        .errWrite(errWrite), .txByte(txByte), .txValid(txValid), .dropCount(dropCount),
        .errorCount(errorCount)
    );

    initial begin
        _RD = 1'b0;
        forever #4 _RD = ~_RD;
    end

    always @(posedge _RD) begin
        cycles++;
        if ((cycleLimit > 0) && (cycles > cycleLimit)) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge _RD);
        #1;
    endtask

    function automatic logic [7:0] randomByte();
        return 8'($random(seed));
    endfunction

    task automatic addStep(input action_e act, input logic [7:0] arg, input logic flagLow);
        steps.push_back('{act, arg, flagLow});
    endtask

    task automatic hostCommand(input hostCmdPkg::cmdOp_e op, input logic [7:0] arg);
        cmdValid = 1'b1;
        cmdOp    = op;
        cmdArg   = arg;
        tick();
        cmdValid = 1'b0;
        cmdOp    = hostCmdPkg::CMD_NOP;
    endtask

    task automatic busRead(input logic flagLow);
        if (flagLow) begin
            while (rxfN !== 1'b0) tick();
        end else if (rxfN !== 1'b1) begin
            tbErrors++;
            $display("read at %0t was meant to hit a high rxfN but rxfN was low", $time);
        end
        rdN = 1'b0;
        tick();
        tick();
        rdN = 1'b1;  // rising edge ends the read
        tick();
    endtask

    task automatic busWrite(input logic [7:0] value, input logic flagLow);
        if (flagLow) begin
            while (txeN !== 1'b0) tick();
        end else if (txeN !== 1'b1) begin
            tbErrors++;
            $display("write at %0t was meant to hit a high txeN but txeN was low", $time);
        end
        dataIn = value;
        wr     = 1'b1;
        tick();
        wr = 1'b0;  // byte taken on this falling wr
        tick();
    endtask

    task automatic takeByte();
        txTake = 1'b1;
        tick();
        txTake = 1'b0;
    endtask

    task automatic runStep(input step_t s);
        case (s.act)
            ACT_RECV:  hostCommand(hostCmdPkg::CMD_RECV, s.arg);
            ACT_GRANT: hostCommand(hostCmdPkg::CMD_GRANT, s.arg);
            ACT_CLEAR: hostCommand(hostCmdPkg::CMD_CLEAR, 8'h00);
            ACT_READ:  busRead(s.flagLow);
            ACT_WRITE: busWrite(s.arg, s.flagLow);
            ACT_TAKE:  takeByte();
            default:   repeat (s.arg) tick();
        endcase
    endtask

    task automatic buildTable();
        addStep(ACT_IDLE, 8'd2, 1'b0);
        addStep(ACT_READ, 8'h00, 1'b0);          // nothing received yet
        addStep(ACT_WRITE, randomByte(), 1'b0);  // no credit yet
        addStep(ACT_RECV, 8'h3C, 1'b0);
        repeat (2) addStep(ACT_RECV, randomByte(), 1'b0);
        repeat (3) addStep(ACT_READ, 8'h00, 1'b1);
        addStep(ACT_READ, 8'h00, 1'b0);
        repeat (10) addStep(ACT_RECV, randomByte(), 1'b0);  // two past the rx depth
        addStep(ACT_IDLE, 8'd2, 1'b0);
        addStep(ACT_CLEAR, 8'h00, 1'b0);
        addStep(ACT_READ, 8'h00, 1'b1);
        addStep(ACT_READ, 8'h00, 1'b0);          // inside the hold-off
        repeat (7) addStep(ACT_READ, 8'h00, 1'b1);
        addStep(ACT_READ, 8'h00, 1'b0);
        addStep(ACT_GRANT, 8'd3, 1'b0);
        repeat (3) addStep(ACT_WRITE, randomByte(), 1'b1);
        addStep(ACT_IDLE, 8'd8, 1'b0);
        addStep(ACT_WRITE, randomByte(), 1'b0);  // credit used up
        repeat (4) addStep(ACT_TAKE, 8'h00, 1'b0);
        addStep(ACT_GRANT, 8'd10, 1'b0);
        repeat (8) addStep(ACT_WRITE, randomByte(), 1'b1);
        addStep(ACT_IDLE, 8'd8, 1'b0);
        addStep(ACT_WRITE, randomByte(), 1'b0);  // tx buffer full
        addStep(ACT_TAKE, 8'h00, 1'b0);
        addStep(ACT_WRITE, randomByte(), 1'b1);
        repeat (8) addStep(ACT_TAKE, 8'h00, 1'b0);
        addStep(ACT_IDLE, 8'd4, 1'b0);
    endtask

    initial begin
        seed     = 11;
        arstN    = 1'b0;
        rdN      = 1'b1;
        wr       = 1'b0;
        dataIn   = 8'h00;
        cmdValid = 1'b0;
        cmdOp    = hostCmdPkg::CMD_NOP;
        cmdArg   = 8'h00;
        txTake   = 1'b0;
        buildTable();
        cycleLimit = steps.size() * 40 + 100;
        repeat (8) @(posedge _RD);
        #1;
        arstN = 1'b1;
        foreach (steps[i]) begin
            runStep(steps[i]);
        end
        tick();
        tick();
        $display("errors: checker %0d, testbench %0d", errorCount, tbErrors);
        if ((errorCount == 0) && (tbErrors == 0)) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* test/usbFifoChecker.sv */
`timescale 1ns/1ps
`include "usbFifo_consts.svh"

// reference model of the chip, compared with the DUT on every falling clock edge
module usbFifoChecker (
    input  logic               _RD,
    input  logic               arstN,
    input  logic               rdN,
    input  logic               wr,
    input  logic [7:0]         dataIn,
    input  logic               cmdValid,
    input  hostCmdPkg::cmdOp_e cmdOp,
    input  logic [7:0]         cmdArg,
    input  logic               txTake,
    input  logic [7:0]         dataOut,
    input  logic               dataOe,
    input  logic               rxfN,
    input  logic               txeN,
    input  logic               errRead,
    input  logic               errWrite,
    input  logic [7:0]         txByte,
    input  logic               txValid,
    input  logic [7:0]         dropCount,
    output int                 errorCount
);

    int                   errors = 0;
    logic [7:0]           rxQ[$];  // unread bytes in injection order
    logic [7:0]           txQ[$];  // written bytes the host has not taken
    logic [`CREDIT_W-1:0] credit;
    logic [7:0]           drops;
    int                   rxHold;  // cycles left with rxfN forced high
    int                   txHold;
    logic                 oeExp;   // high for the whole read strobe
    logic [7:0]           dataExp;
    logic                 errRdExp;
    logic                 errWrExp;
    logic                 rdPrev;
    logic                 wrPrev;

    assign errorCount = errors;

    task automatic compareByte(input string name, input logic [7:0] expVal,
                               input logic [7:0] actVal);
        if (actVal !== expVal) begin
            errors++;
            $display("FAIL time=%0t signal=%s expected=%02h actual=%02h",
                     $time, name, expVal, actVal);
        end
    endtask

    task automatic compareBit(input string name, input logic expVal, input logic actVal);
        compareByte(name, {7'd0, expVal}, {7'd0, actVal});
    endtask

    always @(negedge _RD) begin : modelStep
        logic rxfExp;
        logic txeExp;
        logic rdFall;
        logic rdRise;
        logic wrFall;
        logic accept;
        logic rxFullPre;
        logic txAnyPre;
        if (!arstN) begin
            rxQ.delete();
            txQ.delete();
            credit   = '0;
            drops    = 8'd0;
            rxHold   = 0;
            txHold   = 0;
            oeExp    = 1'b0;
            dataExp  = 8'd0;
            errRdExp = 1'b0;
            errWrExp = 1'b0;
            rdPrev   = 1'b0;
            wrPrev   = 1'b0;
        end else begin
            // flags as they stand before the next rising edge
            rxfExp = !((rxQ.size() != 0) && !oeExp && (rxHold == 0));
            txeExp = !((credit != '0) && (txQ.size() < `TX_DEPTH) && (txHold == 0));

            compareBit("rxfN", rxfExp, rxfN);
            compareBit("txeN", txeExp, txeN);
            compareBit("dataOe", oeExp, dataOe);
            compareBit("errRead", errRdExp, errRead);
            compareBit("errWrite", errWrExp, errWrite);
            compareBit("txValid", txQ.size() != 0, txValid);
            compareByte("dropCount", drops, dropCount);
            if (oeExp) begin
                compareByte("dataOut", dataExp, dataOut);
            end
            if (txQ.size() != 0) begin
                compareByte("txByte", txQ[0], txByte);
            end

            rdFall    = rdPrev && !rdN;
            rdRise    = !rdPrev && rdN;
            wrFall    = wrPrev && !wr;
            accept    = wrFall && !txeExp;
            rxFullPre = rxQ.size() >= `RX_DEPTH;
            txAnyPre  = txQ.size() != 0;
            errRdExp  = rdFall && rxfExp;  // read against a high rxfN
            errWrExp  = wrFall && txeExp;

            if (rdFall && !rxfExp) begin
                oeExp   = 1'b1;
                dataExp = rxQ[0];
            end else if (oeExp && rdRise) begin
                oeExp  = 1'b0;
                rxHold = `RX_HOLD;
                void'(rxQ.pop_front());
            end else if (rxHold > 0) begin
                rxHold--;
            end

            if (accept) begin
                txHold = `TX_HOLD;
                txQ.push_back(dataIn);
            end else if (txHold > 0) begin
                txHold--;
            end
            if (txTake && txAnyPre) begin
                void'(txQ.pop_front());  // head before this edge's push
            end

            if (cmdValid && (cmdOp == hostCmdPkg::CMD_GRANT)) begin
                credit = cmdArg;
            end else if (accept) begin
                credit = credit - `CREDIT_W'(1);
            end
            if (cmdValid && (cmdOp == hostCmdPkg::CMD_RECV)) begin
                if (!rxFullPre) begin
                    rxQ.push_back(cmdArg);
                end else if (drops != 8'hFF) begin
                    drops = drops + 8'd1;  // lost byte
                end
            end
            if (cmdValid && (cmdOp == hostCmdPkg::CMD_CLEAR)) begin
                drops = 8'd0;
            end

            rdPrev = rdN;
            wrPrev = wr;
        end
    end

endmodule

/* design/usbFifoTop.sv */
`timescale 1ns/1ps
`include "usbFifo_consts.svh"

module usbFifoTop (
    input  logic                             _RD,
    input  logic                             arstN,
    input  logic                             rdN,
    input  logic                             wr,
    input  logic [7:0]                       dataIn,
    input  logic                             cmdValid,
    input  hostCmdPkg::cmdOp_e               cmdOp,
    input  logic [hostCmdPkg::CMD_ARG_W-1:0] cmdArg,
    input  logic                             txTake,
    output logic [7:0]                       dataOut,
    output logic                             dataOe,
    output logic                             rxfN,
    output logic                             txeN,
    output logic                             errRead,
    output logic                             errWrite,
    output logic [7:0]                       txByte,
    output logic                             txValid,
    output logic [7:0]                       dropCount
);

    // receive path, host to bus
    logic                 rxPush;
    logic [7:0]           rxData;
    logic                 rxFull;
    logic                 rxEmpty;
    logic [7:0]           rxHead;
    logic                 rxPop;

    // transmit path, bus to host
    logic                 txPush;
    logic [7:0]           txPushData;
    logic                 txFull;
    logic                 txEmpty;
    logic                 grant;
    logic [`CREDIT_W-1:0] grantCount;

    assign txValid = !txEmpty;

    hostControl hostCtrl (
        ._RD(_RD), .arstN(arstN), .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdArg(cmdArg),
        .rxFull(rxFull), .rxPush(rxPush), .rxData(rxData), .grant(grant),
        .grantCount(grantCount), .dropCount(dropCount)
    );

    byteFifo #(.DEPTH(`RX_DEPTH)) rxFifo (
        ._RD(_RD), .arstN(arstN), .push(rxPush), .pop(rxPop), .wrData(rxData),
        .rdData(rxHead), .empty(rxEmpty), .full(rxFull)
    );

    byteFifo #(.DEPTH(`TX_DEPTH)) txFifo (
        ._RD(_RD), .arstN(arstN), .push(txPush), .pop(txTake), .wrData(txPushData),
        .rdData(txByte), .empty(txEmpty), .full(txFull)
    );

    rxPort rxBus (
        ._RD(_RD), .arstN(arstN), .rdN(rdN), .fifoEmpty(rxEmpty), .headByte(rxHead),
        .pop(rxPop), .dataOut(dataOut), .dataOe(dataOe), .rxfN(rxfN), .errRead(errRead)
    );

    txPort txBus (
        ._RD(_RD), .arstN(arstN), .wr(wr), .dataIn(dataIn), .fifoFull(txFull),
        .grant(grant), .grantCount(grantCount), .push(txPush), .pushData(txPushData),
        .txeN(txeN), .errWrite(errWrite)
    );

endmodule

/* design/hostControl.sv */
`timescale 1ns/1ps
`include "usbFifo_consts.svh"

// host command decode, the stand-in for the USB side of the chip
module hostControl (
    input  logic                             _RD,
    input  logic                             arstN,
    input  logic                             cmdValid,
    input  hostCmdPkg::cmdOp_e               cmdOp,
    input  logic [hostCmdPkg::CMD_ARG_W-1:0] cmdArg,
    input  logic                             rxFull,
    output logic                             rxPush,
    output logic [7:0]                       rxData,
    output logic                             grant,
    output logic [`CREDIT_W-1:0]             grantCount,
    output logic [7:0]                       dropCount
);

    logic dropHit;
    logic clearHit;

    assign rxData     = cmdArg;
    assign grantCount = cmdArg;

    always_comb begin
        rxPush   = 1'b0;
        grant    = 1'b0;
        dropHit  = 1'b0;
        clearHit = 1'b0;
        if (cmdValid) begin
            case (cmdOp)
                hostCmdPkg::CMD_RECV: begin
                    rxPush  = !rxFull;
                    dropHit = rxFull; // no room, byte lost
                end
                hostCmdPkg::CMD_GRANT: grant    = 1'b1;
                hostCmdPkg::CMD_CLEAR: clearHit = 1'b1;
                default:               rxPush   = 1'b0; // nop
            endcase
        end
    end

    // lost-byte counter sticks at 255
    always_ff @(posedge _RD or negedge arstN) begin
        if (!arstN) begin
            dropCount <= '0;
        end else if (clearHit) begin
            dropCount <= '0;
        end else if (dropHit && (dropCount != 8'hFF)) begin
            dropCount <= dropCount + 8'd1;
        end
    end

endmodule

/* design/txPort.sv */
`timescale 1ns/1ps
`include "usbFifo_consts.svh"

// bus write side: wr strobe, transmit credit and txeN timing
module txPort (
    input  logic                 _RD,
    input  logic                 arstN,
    input  logic                 wr,
    input  logic [7:0]           dataIn,
    input  logic                 fifoFull,
    input  logic                 grant,
    input  logic [`CREDIT_W-1:0] grantCount,
    output logic                 push,
    output logic [7:0]           pushData,
    output logic                 txeN,
    output logic                 errWrite
);

    localparam int HW = $clog2(`TX_HOLD + 1);

    usbFifoPkg::txState_e state;
    logic [`CREDIT_W-1:0] credit;   // bytes the host still accepts
    logic [HW-1:0]        holdCnt;
    logic                 wrPrev;
    logic                 wrFall;

    assign wrFall = wrPrev && !wr; // data is written on the falling wr

    assign txeN = !((credit != '0) && !fifoFull && (state == usbFifoPkg::TX_IDLE));

    // byte goes straight into the buffer on the accepting edge
    assign push     = wrFall && !txeN;
    assign pushData = dataIn;

    always_ff @(posedge _RD or negedge arstN) begin
        if (!arstN) begin
            state    <= usbFifoPkg::TX_IDLE;
            credit   <= '0;
            holdCnt  <= '0;
            wrPrev   <= 1'b0;
            errWrite <= 1'b0;
        end else begin
            wrPrev   <= wr;
            errWrite <= wrFall && txeN; // write ignored

            if (grant) begin
                credit <= grantCount; // a new grant overrides what is left
            end else if (push) begin
                credit <= credit - `CREDIT_W'(1);
            end

            case (state)
                usbFifoPkg::TX_IDLE: begin
                    if (push) begin
                        state   <= usbFifoPkg::TX_WRITE;
                        holdCnt <= HW'(`TX_HOLD);
                    end
                end
                usbFifoPkg::TX_WRITE: begin
                    state   <= usbFifoPkg::TX_HOLD;
                    holdCnt <= holdCnt - HW'(1);
                end
                usbFifoPkg::TX_HOLD: begin
                    holdCnt <= holdCnt - HW'(1);
                    if (holdCnt == HW'(1)) begin
                        state <= usbFifoPkg::TX_IDLE;
                    end
                end
                default: state <= usbFifoPkg::TX_IDLE;
            endcase
        end
    end

    // an exhausted credit only comes back through a grant
    creditNoWrap: assert property (@(posedge _RD) disable iff (!arstN)
        ((credit == '0) && !grant) |=> (credit == '0))
        else $error("txPort: credit wrapped below zero");

endmodule

/* design/rxPort.sv */
`timescale 1ns/1ps
`include "usbFifo_consts.svh"

// bus read side: rdN strobe handling and rxfN timing
module rxPort (
    input  logic       _RD,
    input  logic       arstN,
    input  logic       rdN,
    input  logic       fifoEmpty,
    input  logic [7:0] headByte,
    output logic       pop,
    output logic [7:0] dataOut,
    output logic       dataOe,
    output logic       rxfN,
    output logic       errRead
);

    localparam int HW = $clog2(`RX_HOLD + 1);

    usbFifoPkg::rxState_e state;
    logic [HW-1:0]        holdCnt;
    logic                 rdPrev;
    logic                 rdFall;
    logic                 rdRise;

    assign rdFall = rdPrev && !rdN;
    assign rdRise = !rdPrev && rdN;

    // ready only when a byte is waiting and no read or hold-off is running
    assign rxfN = !(!fifoEmpty && (state == usbFifoPkg::RX_IDLE));

    // the byte leaves the buffer when the strobe ends, not when it starts
    assign pop = (state == usbFifoPkg::RX_ACTIVE) && rdRise;

    always_ff @(posedge _RD or negedge arstN) begin
        if (!arstN) begin
            state   <= usbFifoPkg::RX_IDLE;
            holdCnt <= '0;
            rdPrev  <= 1'b0; // no false edge out of reset
            dataOe  <= 1'b0;
            errRead <= 1'b0;
        end else begin
            rdPrev  <= rdN;
            errRead <= rdFall && rxfN; // strobe without data ready
            case (state)
                usbFifoPkg::RX_IDLE: begin
                    if (rdFall && !rxfN) begin
                        state  <= usbFifoPkg::RX_ACTIVE;
                        dataOe <= 1'b1;
                    end
                end
                usbFifoPkg::RX_ACTIVE: begin
                    if (rdRise) begin
                        state   <= usbFifoPkg::RX_HOLD;
                        dataOe  <= 1'b0;
                        holdCnt <= HW'(`RX_HOLD);
                    end
                end
                usbFifoPkg::RX_HOLD: begin
                    holdCnt <= holdCnt - HW'(1);
                    if (holdCnt == HW'(1)) begin
                        state <= usbFifoPkg::RX_IDLE; // rxfN may drop next cycle
                    end
                end
                default: state <= usbFifoPkg::RX_IDLE;
            endcase
        end
    end

    // latch the head for the whole strobe
    always_ff @(posedge _RD) begin
        if ((state == usbFifoPkg::RX_IDLE) && rdFall && !rxfN) begin
            dataOut <= headByte;
        end
    end

    popHasData: assert property (@(posedge _RD) disable iff (!arstN) pop |-> !fifoEmpty)
        else $error("rxPort: pop from empty buffer");

    oeOnlyActive: assert property (@(posedge _RD) disable iff (!arstN)
        dataOe |-> (state == usbFifoPkg::RX_ACTIVE))
        else $error("rxPort: dataOe outside a read");

endmodule

/* design/hostCmdPkg.sv */
// host command port encodings
package hostCmdPkg;

    // argument carries a byte or a transmit allowance
    localparam int CMD_ARG_W = 8;

    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_RECV  = 2'd1, // byte arrives from USB into the rx buffer
        CMD_GRANT = 2'd2, // host allows N more bytes to be written
        CMD_CLEAR = 2'd3  // zero the drop counter
    } cmdOp_e;

endpackage

/* design/usbFifoPkg.sv */
// bus-side state encodings for the read and write ports
package usbFifoPkg;

    // read port: idle, strobe in progress, post-read hold-off
    typedef enum logic [1:0] {
        RX_IDLE   = 2'd0,
        RX_ACTIVE = 2'd1, // rdN low, data on the bus
        RX_HOLD   = 2'd2  // rxfN forced high after the read
    } rxState_e;

    // write port: idle, byte just accepted, post-write hold-off
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_WRITE = 2'd1, // first cycle after the accepting wr edge
        TX_HOLD  = 2'd2  // rest of the txeN hold-off
    } txState_e;

endpackage

/* design/byteFifo.sv */
`timescale 1ns/1ps

// show-ahead ring buffer: rdData is the head whenever empty is low
module byteFifo #(
    parameter int DEPTH = 8
) (
    input  logic       _RD,
    input  logic       arstN,
    input  logic       push,
    input  logic       pop,
    input  logic [7:0] wrData,
    output logic [7:0] rdData,
    output logic       empty,
    output logic       full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wrPtr;
    logic [AW-1:0] rdPtr;
    logic [CW-1:0] count;
    logic          wrEn;
    logic          rdEn;

    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));
    assign wrEn  = push && !full;  // overflow push dropped
    assign rdEn  = pop && !empty;  // underflow pop dropped

    assign rdData = mem[rdPtr];

    // pointer and occupancy bookkeeping
    always_ff @(posedge _RD or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= (wrPtr == AW'(DEPTH - 1)) ? '0 : wrPtr + AW'(1);
            end
            if (rdEn) begin
                rdPtr <= (rdPtr == AW'(DEPTH - 1)) ? '0 : rdPtr + AW'(1);
            end
            case ({wrEn, rdEn})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count; // both or neither
            endcase
        end
    end

    always_ff @(posedge _RD) begin
        if (wrEn) begin
            mem[wrPtr] <= wrData;
        end
    end

    // every caller gates its push on full
    pushNotFull: assert property (@(posedge _RD) disable iff (!arstN) !(push && full))
        else $error("byteFifo: push while full");

endmodule

/* design/usbFifo_consts.svh */
`ifndef USB_FIFO_CONSTS_SVH
`define USB_FIFO_CONSTS_SVH

// buffer depths in bytes
`define RX_DEPTH 8
`define TX_DEPTH 8

// hold-off lengths in _RD cycles
`define RX_HOLD 4 // rxfN high after a read ends
`define TX_HOLD 6 // txeN high after an accepted write

// transmit allowance counter width
`define CREDIT_W 8

`endif
